/* source/aes_dec_consts.svh */
`ifndef AES_DEC_CONSTS_SVH
`define AES_DEC_CONSTS_SVH

// AES-128 round count
`define AES_ROUNDS 10

// Register byte addresses, KEY0 is the most significant word
`define AES_REG_KEY0   6'h00
`define AES_REG_KEY1   6'h04
`define AES_REG_KEY2   6'h08
`define AES_REG_KEY3   6'h0C
`define AES_REG_DATA0  6'h10
`define AES_REG_DATA1  6'h14
`define AES_REG_DATA2  6'h18
`define AES_REG_DATA3  6'h1C
`define AES_REG_CTRL   6'h20
`define AES_REG_STATUS 6'h24

// Bit positions
`define AES_CTRL_START 0
`define AES_ST_BUSY    0
`define AES_ST_DONE    1

`endif

/* source/aes_dec_pkg.sv */
`default_nettype none

package aes_dec_pkg;

    typedef logic [127:0] aes_block_t;  // Byte 0 in bits 127:120

    typedef enum logic [1:0] {
        KEY_HOLD = 2'b00,
        KEY_LOAD = 2'b01,
        KEY_FWD  = 2'b10,
        KEY_REV  = 2'b11
    } key_op_t;

    typedef struct packed {
        logic load;  // State <= ciphertext ^ round key
        logic step;  // One inverse round
        logic last;  // Final round, no InvMixColumns
    } round_ctrl_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [5:0]  adr;  // Byte address
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_rsp_t;

    // Multiply by x modulo the AES polynomial
    function automatic logic [7:0] gf_xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] aa;
        p  = 8'h00;
        aa = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) p = p ^ aa;
            aa = gf_xtime(aa);
        end
        return p;
    endfunction

endpackage

`default_nettype wire

/* source/aes_sbox.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_sbox #(
    parameter bit INVERSE = 1'b0  // 0 forward, 1 inverse
) (
    input  logic [31:0] in,
    output logic [31:0] out
);

    import aes_dec_pkg::*;

    // x^254 by square and multiply, maps 0 to 0
    function automatic logic [7:0] gf_inv(input logic [7:0] x);
        logic [7:0] sq;
        logic [7:0] acc;
        sq  = gf_mul(x, x);
        acc = sq;
        for (int i = 0; i < 6; i++) begin
            sq  = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    function automatic logic [7:0] affine_fwd(input logic [7:0] b);
        return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
                 ^ {b[3:0], b[7:4]} ^ 8'h63;
    endfunction

    function automatic logic [7:0] affine_inv(input logic [7:0] s);
        return {s[6:0], s[7]} ^ {s[4:0], s[7:5]} ^ {s[1:0], s[7:2]} ^ 8'h05;
    endfunction

    function automatic logic [7:0] sub_byte(input logic [7:0] b);
        if (INVERSE)
            return gf_inv(affine_inv(b));  // Undo affine first
        else
            return affine_fwd(gf_inv(b));
    endfunction

    for (genvar g = 0; g < 4; g++) begin : g_byte
        assign out[8*g +: 8] = sub_byte(in[8*g +: 8]);
    end

endmodule

`default_nettype wire

/* source/aes_key_expander.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_key_expander (
    input  logic                    clk,
    input  logic                    rst_n,
    input  aes_dec_pkg::key_op_t    key_op,
    input  aes_dec_pkg::aes_block_t load_key,
    input  logic [3:0]              rcon_round,
    output aes_dec_pkg::aes_block_t round_key
);

    import aes_dec_pkg::*;

    logic [31:0] w0, w1, w2, w3;
    logic [31:0] prev_w3;    // Word 3 of the previous round key
    logic [31:0] sub_in;
    logic [31:0] sub_out;
    logic [31:0] rcon_word;
    logic [31:0] fwd_w0;
    aes_block_t  fwd_key;
    aes_block_t  rev_key;

    function automatic logic [7:0] rcon(input logic [3:0] r);
        case (r)
            4'd1:    return 8'h01;
            4'd2:    return 8'h02;
            4'd3:    return 8'h04;
            4'd4:    return 8'h08;
            4'd5:    return 8'h10;
            4'd6:    return 8'h20;
            4'd7:    return 8'h40;
            4'd8:    return 8'h80;
            4'd9:    return 8'h1b;
            4'd10:   return 8'h36;
            default: return 8'h00;
        endcase
    endfunction

    assign w0 = round_key[127:96];
    assign w1 = round_key[95:64];
    assign w2 = round_key[63:32];
    assign w3 = round_key[31:0];

    assign prev_w3 = w3 ^ w2;

    // One S-box serves both directions, RotWord on the way in
    assign sub_in = (key_op == KEY_REV) ? {prev_w3[23:0], prev_w3[31:24]}
                                        : {w3[23:0], w3[31:24]};

    aes_sbox #(
        .INVERSE(1'b0)
    ) u_sbox (
        .in (sub_in),
        .out(sub_out)
    );

    assign rcon_word = {rcon(rcon_round), 24'h000000};

    assign fwd_w0  = w0 ^ sub_out ^ rcon_word;
    assign fwd_key = {fwd_w0, fwd_w0 ^ w1, fwd_w0 ^ w1 ^ w2, fwd_w0 ^ w1 ^ w2 ^ w3};

    // Reverse step, words 3..1 from neighbours then word 0
    assign rev_key = {w0 ^ sub_out ^ rcon_word, w1 ^ w0, w2 ^ w1, prev_w3};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            round_key <= '0;
        end else begin
            case (key_op)
                KEY_LOAD: round_key <= load_key;
                KEY_FWD:  round_key <= fwd_key;
                KEY_REV:  round_key <= rev_key;
                default:  round_key <= round_key;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/aes_dec_round.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_dec_round (
    input  logic                     clk,
    input  logic                     rst_n,
    input  aes_dec_pkg::round_ctrl_t ctrl,
    input  aes_dec_pkg::aes_block_t  ciphertext,
    input  aes_dec_pkg::aes_block_t  round_key,
    output aes_dec_pkg::aes_block_t  state
);

    import aes_dec_pkg::*;

    aes_block_t shifted;
    aes_block_t subbed;
    aes_block_t keyed;
    aes_block_t mixed;
    aes_block_t state_nxt;

    // Column a0..a3 with a0 in the top byte
    function automatic logic [31:0] inv_mix_col(input logic [31:0] c);
        logic [7:0] a0, a1, a2, a3;
        a0 = c[31:24];
        a1 = c[23:16];
        a2 = c[15:8];
        a3 = c[7:0];
        return {gf_mul(a0, 8'h0e) ^ gf_mul(a1, 8'h0b) ^ gf_mul(a2, 8'h0d) ^ gf_mul(a3, 8'h09),
                gf_mul(a0, 8'h09) ^ gf_mul(a1, 8'h0e) ^ gf_mul(a2, 8'h0b) ^ gf_mul(a3, 8'h0d),
                gf_mul(a0, 8'h0d) ^ gf_mul(a1, 8'h09) ^ gf_mul(a2, 8'h0e) ^ gf_mul(a3, 8'h0b),
                gf_mul(a0, 8'h0b) ^ gf_mul(a1, 8'h0d) ^ gf_mul(a2, 8'h09) ^ gf_mul(a3, 8'h0e)};
    endfunction

    // InvShiftRows, row r rotates right by r columns
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted[127 - 8*(4*c + r) -: 8] = state[127 - 8*(4*((c + 4 - r) % 4) + r) -: 8];
            end
        end
    end

    for (genvar g = 0; g < 4; g++) begin : g_col
        aes_sbox #(
            .INVERSE(1'b1)
        ) u_inv_sbox (
            .in (shifted[127 - 32*g -: 32]),
            .out(subbed[127 - 32*g -: 32])
        );

        assign mixed[127 - 32*g -: 32] = inv_mix_col(keyed[127 - 32*g -: 32]);
    end

    assign keyed     = subbed ^ round_key;
    assign state_nxt = ctrl.last ? keyed : mixed;  // Final round skips the mix

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= '0;
        end else if (ctrl.load) begin
            state <= ciphertext ^ round_key;  // Initial AddRoundKey with K10
        end else if (ctrl.step) begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

/* source/aes_dec_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_dec_consts.svh"

module aes_dec_controller (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  aes_dec_pkg::aes_block_t  key,
    input  aes_dec_pkg::aes_block_t  round_key,
    output aes_dec_pkg::key_op_t     key_op,
    output aes_dec_pkg::aes_block_t  load_key,
    output logic [3:0]               rcon_round,
    output aes_dec_pkg::round_ctrl_t round_ctrl,
    output logic                     busy,
    output logic                     done
);

    import aes_dec_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        EXPAND,     // Forward expansion up to K10
        START_DEC,  // Initial AddRoundKey
        DECRYPT
    } state_t;

    state_t     state, state_nxt;
    logic [3:0] cnt;          // Round index of the key in the expander
    aes_block_t cache_key;
    aes_block_t cache_k10;
    logic       cache_valid;
    logic       key_hit;

    assign key_hit  = cache_valid && (cache_key == key);
    assign load_key = key_hit ? cache_k10 : key;  // Skip expansion on a repeat key
    assign busy     = (state != IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:      if (start) state_nxt = key_hit ? START_DEC : EXPAND;
            EXPAND:    if (cnt == 4'(`AES_ROUNDS)) state_nxt = START_DEC;
            START_DEC: state_nxt = DECRYPT;
            DECRYPT:   if (cnt == 4'd0) state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) state <= IDLE;
        else        state <= state_nxt;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= 4'd0;
        end else begin
            case (state)
                IDLE:      if (start) cnt <= 4'd1;
                EXPAND:    cnt <= cnt + 4'd1;
                START_DEC: cnt <= 4'(`AES_ROUNDS - 1);
                DECRYPT:   if (cnt != 4'd0) cnt <= cnt - 4'd1;
                default:   cnt <= cnt;
            endcase
        end
    end

    // Key cache, written only when a run actually starts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cache_key   <= '0;
            cache_k10   <= '0;
            cache_valid <= 1'b0;
        end else begin
            if (state == IDLE && start) begin
                cache_key   <= key;
                cache_valid <= 1'b1;
            end
            if (state == START_DEC) cache_k10 <= round_key;  // Expander holds K10 here
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) done <= 1'b0;
        else        done <= (state == DECRYPT) && (cnt == 4'd0);
    end

    always_comb begin
        key_op     = KEY_HOLD;
        rcon_round = 4'd0;
        round_ctrl = '0;
        case (state)
            IDLE: begin
                if (start) key_op = KEY_LOAD;
            end
            EXPAND: begin
                key_op     = KEY_FWD;
                rcon_round = cnt;
            end
            START_DEC: begin
                key_op          = KEY_REV;  // K10 back to K9
                rcon_round      = 4'(`AES_ROUNDS);
                round_ctrl.load = 1'b1;
            end
            DECRYPT: begin
                round_ctrl.step = 1'b1;
                rcon_round      = cnt;
                if (cnt == 4'd0) round_ctrl.last = 1'b1;
                else             key_op = KEY_REV;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/aes_dec_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_dec_consts.svh"

module aes_dec_wb_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  aes_dec_pkg::wb_req_t    wb_req,
    output aes_dec_pkg::wb_rsp_t    wb_rsp,
    output aes_dec_pkg::aes_block_t key,
    output aes_dec_pkg::aes_block_t ciphertext,
    input  aes_dec_pkg::aes_block_t plaintext,
    output logic                    start,
    input  logic                    busy,
    input  logic                    done
);

    logic        ack_q;
    logic [31:0] rdata_q;
    logic [31:0] rd_mux;
    logic        req_new;  // First cycle of a request
    logic        wr_en;
    logic        done_q;   // Sticky until the next start

    assign req_new = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr_en   = req_new && wb_req.we;

    // Ignored while a block is in flight
    assign start = wr_en && (wb_req.adr == `AES_REG_CTRL)
                   && wb_req.dat[`AES_CTRL_START] && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) ack_q <= 1'b0;
        else        ack_q <= req_new;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (wb_req.adr)
                `AES_REG_KEY0:  key[127:96]        <= wb_req.dat;
                `AES_REG_KEY1:  key[95:64]         <= wb_req.dat;
                `AES_REG_KEY2:  key[63:32]         <= wb_req.dat;
                `AES_REG_KEY3:  key[31:0]          <= wb_req.dat;
                `AES_REG_DATA0: ciphertext[127:96] <= wb_req.dat;
                `AES_REG_DATA1: ciphertext[95:64]  <= wb_req.dat;
                `AES_REG_DATA2: ciphertext[63:32]  <= wb_req.dat;
                `AES_REG_DATA3: ciphertext[31:0]   <= wb_req.dat;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)    done_q <= 1'b0;
        else if (start) done_q <= 1'b0;
        else if (done)  done_q <= 1'b1;
    end

    // DATA reads return the plaintext, not the written ciphertext
    always_comb begin
        rd_mux = 32'h0;
        case (wb_req.adr)
            `AES_REG_KEY0:   rd_mux = key[127:96];
            `AES_REG_KEY1:   rd_mux = key[95:64];
            `AES_REG_KEY2:   rd_mux = key[63:32];
            `AES_REG_KEY3:   rd_mux = key[31:0];
            `AES_REG_DATA0:  rd_mux = plaintext[127:96];
            `AES_REG_DATA1:  rd_mux = plaintext[95:64];
            `AES_REG_DATA2:  rd_mux = plaintext[63:32];
            `AES_REG_DATA3:  rd_mux = plaintext[31:0];
            `AES_REG_STATUS: begin
                rd_mux[`AES_ST_BUSY] = busy;
                rd_mux[`AES_ST_DONE] = done_q;
            end
            default: rd_mux = 32'h0;  // CTRL reads as zero too
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_new && !wb_req.we) rdata_q <= rd_mux;
    end

    assign wb_rsp = '{dat: rdata_q, ack: ack_q};

endmodule

`default_nettype wire

/* source/aes_dec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_dec_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  aes_dec_pkg::wb_req_t wb_req,
    output aes_dec_pkg::wb_rsp_t wb_rsp
);

    import aes_dec_pkg::*;

    aes_block_t  key;
    aes_block_t  ciphertext;
    aes_block_t  plaintext;
    aes_block_t  load_key;
    aes_block_t  round_key;
    logic        start;
    logic        busy;
    logic        done;
    key_op_t     key_op;
    logic [3:0]  rcon_round;
    round_ctrl_t round_ctrl;

    aes_dec_wb_regs u_wb_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .key       (key),
        .ciphertext(ciphertext),
        .plaintext (plaintext),
        .start     (start),
        .busy      (busy),
        .done      (done)
    );

    aes_dec_controller u_controller (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .key       (key),
        .round_key (round_key),
        .key_op    (key_op),
        .load_key  (load_key),
        .rcon_round(rcon_round),
        .round_ctrl(round_ctrl),
        .busy      (busy),
        .done      (done)
    );

    aes_key_expander u_key_expander (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_op    (key_op),
        .load_key  (load_key),
        .rcon_round(rcon_round),
        .round_key (round_key)
    );

    aes_dec_round u_dec_round (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (round_ctrl),
        .ciphertext(ciphertext),
        .round_key (round_key),
        .state     (plaintext)
    );

endmodule

`default_nettype wire

/* sim/aes_dec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_dec_consts.svh"

module aes_dec_tb;

    import aes_dec_pkg::*;

    typedef enum logic [2:0] {
        OP_STATUS,    // Read STATUS and compare with exp[31:0]
        OP_KEY_RB,    // Key write then read back
        OP_DEC,       // One block through the core
        OP_DEC_BUSY,  // Same plus a second start while busy
        OP_UNMAPPED   // Read of an unused address
    } op_t;

    typedef struct packed {
        op_t        op;
        logic [5:0] adr;
        aes_block_t key;
        aes_block_t data;  // Ciphertext
        aes_block_t exp;   // Plaintext or register value
    } row_t;

    localparam int NUM_ROWS    = 10;
    localparam int CYCLE_LIMIT = NUM_ROWS * 40 + 200;
    localparam int ACK_WAIT    = 8;
    localparam int POLL_LIMIT  = 40;

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    row_t rows [NUM_ROWS];
    int   errors      = 0;
    int   passed      = 0;
    int   failed      = 0;
    int   cycles      = 0;
    int   done_pulses = 0;

    aes_dec_top u_aes_dec_top (
        .clk   (clk),
        .rst_n (rst_n),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles with tests still pending", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Count completion pulses inside the core
    always @(negedge clk) begin
        if (u_aes_dec_top.done) done_pulses = done_pulses + 1;
    end

    function automatic string op_label(input op_t op);
        case (op)
            OP_STATUS:   return "status after reset";
            OP_KEY_RB:   return "key read back";
            OP_DEC:      return "decrypt";
            OP_DEC_BUSY: return "decrypt with start while busy";
            default:     return "unmapped read";
        endcase
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Request goes out on a rising edge and ack is sampled on falling edges
    task automatic bus_access(input logic we, input logic [5:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        bit acked;
        waited = 0;
        acked  = 1'b0;
        rdat   = 32'h0;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        while (!acked && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
            if (wb_rsp.ack) begin
                acked = 1'b1;
                rdat  = wb_rsp.dat;
            end
        end
        if (!acked) begin
            $display("No ack for the access to address %h within %0d cycles", adr, ACK_WAIT);
            errors++;
        end
        @(posedge clk);
        wb_req <= '0;
        @(negedge clk);
        if (acked && wb_rsp.ack) begin
            $display("Ack stayed high a second cycle for address %h", adr);
            errors++;
        end
    endtask

    task automatic wb_write(input logic [5:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [5:0] adr, output logic [31:0] dat);
        bus_access(1'b0, adr, 32'h0, dat);
    endtask

    task automatic write_block(input logic [5:0] base, input aes_block_t blk);
        for (int i = 0; i < 4; i++) begin
            wb_write(base + 6'(4 * i), blk[127 - 32*i -: 32]);  // Word 0 is the top word
        end
    endtask

    task automatic run_decrypt(input row_t r);
        logic [31:0] rd;
        int          polls;
        int          pulses_at_start;
        write_block(`AES_REG_KEY0, r.key);
        write_block(`AES_REG_DATA0, r.data);
        pulses_at_start = done_pulses;
        wb_write(`AES_REG_CTRL, 32'h1 << `AES_CTRL_START);
        wb_read(`AES_REG_STATUS, rd);
        check_word("STATUS.busy after start", 32'(rd[`AES_ST_BUSY]), 32'h1);
        if (r.op == OP_DEC_BUSY) begin
            wb_write(`AES_REG_CTRL, 32'h1 << `AES_CTRL_START);  // Core should drop this one
        end
        polls = 0;
        rd    = 32'h0;
        while (!rd[`AES_ST_DONE] && polls < POLL_LIMIT) begin
            wb_read(`AES_REG_STATUS, rd);
            polls++;
        end
        if (!rd[`AES_ST_DONE]) begin
            $display("Done bit never set after %0d status polls", polls);
            errors++;
            return;
        end
        check_word("STATUS.busy after done", 32'(rd[`AES_ST_BUSY]), 32'h0);
        if (r.op == OP_DEC_BUSY) begin
            repeat (30) @(negedge clk);  // Time for a second run to show up
        end
        for (int i = 0; i < 4; i++) begin
            wb_read(`AES_REG_DATA0 + 6'(4 * i), rd);
            check_word($sformatf("DATA%0d", i), rd, r.exp[127 - 32*i -: 32]);
        end
        check_word("done pulse count", 32'(done_pulses - pulses_at_start), 32'h1);
    endtask

    task automatic run_row(input row_t r);
        logic [31:0] rd;
        case (r.op)
            OP_STATUS: begin
                wb_read(r.adr, rd);
                check_word("STATUS", rd, r.exp[31:0]);
            end
            OP_KEY_RB: begin
                write_block(`AES_REG_KEY0, r.key);
                for (int i = 0; i < 4; i++) begin
                    wb_read(`AES_REG_KEY0 + 6'(4 * i), rd);
                    check_word($sformatf("KEY%0d", i), rd, r.key[127 - 32*i -: 32]);
                end
            end
            OP_DEC, OP_DEC_BUSY: run_decrypt(r);
            default: begin
                wb_read(r.adr, rd);
                check_word("unmapped read data", rd, r.exp[31:0]);
            end
        endcase
    endtask

    // FIPS-197 appendices B and C.1, SP 800-38A ECB blocks and the all-zero key
    task automatic load_table();
        rows[0] = '{OP_STATUS, `AES_REG_STATUS, '0, '0, '0};
        rows[1] = '{OP_KEY_RB, 6'h00, 128'h0123456789abcdeffedcba9876543210, '0, '0};
        rows[2] = '{OP_DEC, 6'h00,  // Zero key before the cache holds anything
                    128'h00000000000000000000000000000000,
                    128'h66e94bd4ef8a2c3b884cfa59ca342b2e,
                    128'h00000000000000000000000000000000};
        rows[3] = '{OP_DEC, 6'h00,
                    128'h000102030405060708090a0b0c0d0e0f,
                    128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                    128'h00112233445566778899aabbccddeeff};
        rows[4] = '{OP_DEC, 6'h00,
                    128'h2b7e151628aed2a6abf7158809cf4f3c,
                    128'h3925841d02dc09fbdc118597196a0b32,
                    128'h3243f6a8885a308d313198a2e0370734};
        rows[5] = '{OP_DEC, 6'h00,  // Same key hits the cached K10
                    128'h2b7e151628aed2a6abf7158809cf4f3c,
                    128'h3ad77bb40d7a3660a89ecaf32466ef97,
                    128'h6bc1bee22e409f96e93d7e117393172a};
        rows[6] = '{OP_DEC, 6'h00,
                    128'h000102030405060708090a0b0c0d0e0f,
                    128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                    128'h00112233445566778899aabbccddeeff};
        rows[7] = '{OP_DEC_BUSY, 6'h00,
                    128'h2b7e151628aed2a6abf7158809cf4f3c,
                    128'hf5d3d58503b9699de785895a96fdbaaf,
                    128'hae2d8a571e03ac9c9eb76fac45af8e51};
        rows[8] = '{OP_UNMAPPED, 6'h28, '0, '0, '0};
        rows[9] = '{OP_UNMAPPED, 6'h3C, '0, '0, '0};
    endtask

    initial begin
        wb_req = '0;
        rst_n  = 1'b0;
        load_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            int errors_before;
            errors_before = errors;
            run_row(rows[i]);
            if (errors == errors_before) begin
                passed++;
                $display("Row %0d %s: pass", i, op_label(rows[i].op));
            end else begin
                failed++;
                $display("Row %0d %s: fail", i, op_label(rows[i].op));
            end
        end
        $display("Rows passed %0d, rows failed %0d", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* aes_dec.f */
+incdir+source
source/aes_dec_pkg.sv
source/aes_sbox.sv
source/aes_key_expander.sv
source/aes_dec_round.sv
source/aes_dec_controller.sv
source/aes_dec_wb_regs.sv
source/aes_dec_top.sv
sim/aes_dec_tb.sv

/* Bender.yml */
package:
  name: aes_dec

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/aes_dec_pkg.sv
      - source/aes_sbox.sv
      - source/aes_key_expander.sv
      - source/aes_dec_round.sv
      - source/aes_dec_controller.sv
      - source/aes_dec_wb_regs.sv
      - source/aes_dec_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/aes_dec_tb.sv
